// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := tb_pipe_ctrl
FILELIST := tb.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := verif/tb_tasks.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)

// ==== common/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    import isa_pkg::*;

    //////////////////////////////////////////////////
    // job handed from decode to the back stages
    //////////////////////////////////////////////////

    typedef struct packed
    {
        mem_kind_t mem_kind;
        wb_kind_t  wb_kind;
    } job_t;

    //////////////////////////////////////////////////
    // per-stage control strobes
    //////////////////////////////////////////////////

    // instruction stage
    typedef struct packed
    {
        logic i_req;
        logic ir_load;
        logic operand_load;
        logic pc_inc;
        logic pc_reload;
        logic int_save;
        logic int_vector;
    } fetch_ctrl_t;

    // execute, alu_op only meaningful with alu_en
    typedef struct packed
    {
        logic    alu_en;
        alu_op_t alu_op;
        logic    trap;
    } exec_ctrl_t;

    // data bus and io port
    typedef struct packed
    {
        logic d_req;
        logic d_write;
        logic io_sel;
        logic io_dir;
    } mem_ctrl_t;

    typedef struct packed
    {
        logic reg_write;
        logic reg_src_mem;
        logic pc_write;
    } wb_ctrl_t;

endpackage

`default_nettype wire

// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    //////////////////////////////////////////////////
    // instruction encoding
    //////////////////////////////////////////////////

    typedef logic [5:0] opcode_t;
    typedef logic [4:0] alu_op_t;

    // 00..37 octal are alu ops, an odd code carries an immediate word
    localparam opcode_t OP_LOAD  = 6'o40;
    localparam opcode_t OP_STORE = 6'o41;
    localparam opcode_t OP_IN    = 6'o42;
    localparam opcode_t OP_OUT   = 6'o43;
    localparam opcode_t OP_JUMP  = 6'o44;

    //////////////////////////////////////////////////
    // work classes left after execute
    //////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE,
        MEM_IN,
        MEM_OUT
    } mem_kind_t;

    typedef enum logic [1:0]
    {
        WB_NONE,
        WB_ALU,
        WB_MEM,
        WB_PC
    } wb_kind_t;

    // alu class is the lower half of the opcode space
    function automatic logic is_alu(opcode_t op);
        return ~op[5];
    endfunction

    function automatic logic has_immediate(opcode_t op);
        return is_alu(op) && op[0];
    endfunction

    function automatic alu_op_t alu_op_of(opcode_t op);
        return op[4:0];
    endfunction

endpackage

`default_nettype wire

// ==== fetch/fetch_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_sequencer
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire opcode_t opcode,
    input  wire logic    i_odv,
    input  wire logic    i_pending,
    input  wire logic    pc_w,
    input  wire logic    full,
    output logic         push,
    output job_t         push_job,
    output fetch_ctrl_t  fetch_ctrl,
    output exec_ctrl_t   exec_ctrl
);

    typedef enum logic [3:0]
    {
        F_IDLE,
        F_RELOAD,
        F_INT_SAVE,
        F_INT_VECTOR,
        F_FETCH,
        F_DECODE,
        F_EXECUTE,
        F_IMM_FETCH,
        F_ISSUE
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t next_state;

    // decode result, held from decode through issue
    job_t    dec_job;
    alu_op_t dec_op;
    logic    dec_illegal;
    logic    dec_imm;
    logic    job_empty;

    job_t job_d;
    logic illegal_d;

    //////////////////////////////////////////////////
    // opcode decode
    //////////////////////////////////////////////////

    always_comb
    begin
        job_d = '{MEM_NONE, WB_NONE};
        illegal_d = 1'b0;
        if (is_alu(opcode))
        begin
            job_d.wb_kind = WB_ALU;
        end
        else
        begin
            case (opcode)
                OP_LOAD:  job_d = '{MEM_LOAD, WB_MEM};
                OP_STORE: job_d = '{MEM_STORE, WB_NONE};
                OP_IN:    job_d = '{MEM_IN, WB_NONE};
                OP_OUT:   job_d = '{MEM_OUT, WB_NONE};
                OP_JUMP:  job_d = '{MEM_NONE, WB_PC};
                default:  illegal_d = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == F_DECODE)
        begin
            dec_job     <= job_d;
            dec_op      <= alu_op_of(opcode);
            dec_illegal <= illegal_d;
            dec_imm     <= has_immediate(opcode);
        end
    end

    // nothing left for the back stages
    assign job_empty = (dec_job.mem_kind == MEM_NONE) && (dec_job.wb_kind == WB_NONE);

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= F_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            F_IDLE:
            begin
                if (pc_w)
                    next_state = F_RELOAD;
                else if (i_pending)
                    next_state = F_INT_SAVE;
                else
                    next_state = F_FETCH;
            end
            F_RELOAD:     next_state = i_pending ? F_INT_SAVE : F_FETCH;
            F_INT_SAVE:   next_state = F_INT_VECTOR;
            F_INT_VECTOR: next_state = F_FETCH;
            F_FETCH:      if (i_odv) next_state = F_DECODE;
            F_DECODE:     next_state = F_EXECUTE;
            F_EXECUTE:
            begin
                // illegal opcodes have an empty job and drop out here
                if (job_empty)
                    next_state = F_IDLE;
                else if (dec_imm)
                    next_state = F_IMM_FETCH;
                else
                    next_state = F_ISSUE;
            end
            F_IMM_FETCH:  if (i_odv) next_state = F_ISSUE;
            F_ISSUE:      if (!full) next_state = F_IDLE;
            default:      next_state = F_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////

    always_comb
    begin
        fetch_ctrl = '0;
        exec_ctrl = '0;
        push = 1'b0;
        case (state)
            F_RELOAD:     fetch_ctrl.pc_reload = 1'b1;
            F_INT_SAVE:   fetch_ctrl.int_save = 1'b1;
            F_INT_VECTOR: fetch_ctrl.int_vector = 1'b1;
            F_FETCH:
            begin
                fetch_ctrl.i_req = 1'b1;
                fetch_ctrl.ir_load = i_odv;
                fetch_ctrl.pc_inc = i_odv;
            end
            F_EXECUTE:
            begin
                exec_ctrl.trap = dec_illegal;
                if (dec_job.wb_kind == WB_ALU)
                begin
                    exec_ctrl.alu_en = 1'b1;
                    exec_ctrl.alu_op = dec_op;
                end
            end
            F_IMM_FETCH:
            begin
                fetch_ctrl.i_req = 1'b1;
                fetch_ctrl.operand_load = i_odv;
                fetch_ctrl.pc_inc = i_odv;
            end
            F_ISSUE:      push = !full;
            default:      push = 1'b0;
        endcase
    end

    assign push_job = dec_job;

endmodule

`default_nettype wire

// ==== hdl/job_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module job_queue
    import ctrl_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic push,
    input  wire job_t push_job,
    input  wire logic pop,
    output job_t      pop_job,
    output logic      full,
    output logic      empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(FIFO_DEPTH - 1);

    job_t slots [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (do_push)
            slots[wr_ptr] <= push_job;
    end

    //////////////////////////////////////////////////
    // pointers and fill level
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head is visible the cycle after its push
    assign pop_job = slots[rd_ptr];
    assign full = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== hdl/pipe_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_ctrl_top
    import isa_pkg::*, ctrl_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
)
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire opcode_t opcode,
    input  wire logic    i_odv,
    input  wire logic    d_odv,
    input  wire logic    hs_in,
    input  wire logic    i_pending,
    input  wire logic    pc_w,
    output fetch_ctrl_t  fetch_ctrl,
    output exec_ctrl_t   exec_ctrl,
    output mem_ctrl_t    mem_ctrl,
    output wb_ctrl_t     wb_ctrl,
    output logic         hs_out
);

    //////////////////////////////////////////////////
    // stage to stage wiring
    //////////////////////////////////////////////////

    // decode to queue
    logic push;
    job_t push_job;
    logic full;

    // queue to memory stage
    logic pop;
    job_t pop_job;
    logic empty;

    // memory stage to writeback
    logic     wb_start;
    wb_kind_t wb_kind;
    logic     wb_busy;

    fetch_sequencer u_fetch
    (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .i_odv      (i_odv),
        .i_pending  (i_pending),
        .pc_w       (pc_w),
        .full       (full),
        .push       (push),
        .push_job   (push_job),
        .fetch_ctrl (fetch_ctrl),
        .exec_ctrl  (exec_ctrl)
    );

    job_queue #(.FIFO_DEPTH(FIFO_DEPTH)) u_queue
    (
        .clk      (clk),
        .reset    (reset),
        .push     (push),
        .push_job (push_job),
        .pop      (pop),
        .pop_job  (pop_job),
        .full     (full),
        .empty    (empty)
    );

    mem_sequencer u_mem
    (
        .clk      (clk),
        .reset    (reset),
        .empty    (empty),
        .pop_job  (pop_job),
        .d_odv    (d_odv),
        .hs_in    (hs_in),
        .wb_busy  (wb_busy),
        .pop      (pop),
        .wb_start (wb_start),
        .wb_kind  (wb_kind),
        .mem_ctrl (mem_ctrl),
        .hs_out   (hs_out)
    );

    writeback_sequencer u_wb
    (
        .clk      (clk),
        .reset    (reset),
        .wb_start (wb_start),
        .wb_kind  (wb_kind),
        .d_odv    (d_odv),
        .wb_busy  (wb_busy),
        .wb_ctrl  (wb_ctrl)
    );

endmodule

`default_nettype wire

// ==== memstage/mem_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_sequencer
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic empty,
    input  wire job_t pop_job,
    input  wire logic d_odv,
    input  wire logic hs_in,
    input  wire logic wb_busy,
    output logic      pop,
    output logic      wb_start,
    output wb_kind_t  wb_kind,
    output mem_ctrl_t mem_ctrl,
    output logic      hs_out
);

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_DATA_REQ,
        M_DATA_HOLD,
        M_IO_WAIT,
        M_IO_HANDSHAKE,
        M_WB
    } mem_state_t;

    mem_state_t state;
    mem_state_t next_state;
    job_t       cur_job;
    logic       is_store;
    logic       is_out;

    always_ff @(posedge clk)
    begin
        if (pop)
            cur_job <= pop_job;
    end

    assign is_store = (cur_job.mem_kind == MEM_STORE);
    assign is_out = (cur_job.mem_kind == MEM_OUT);
    assign wb_kind = cur_job.wb_kind;

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= M_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            M_IDLE:
            begin
                if (!empty)
                begin
                    case (pop_job.mem_kind)
                        MEM_LOAD, MEM_STORE: next_state = M_DATA_REQ;
                        MEM_IN, MEM_OUT:     next_state = M_IO_WAIT;
                        default:
                            next_state = (pop_job.wb_kind == WB_NONE) ? M_IDLE : M_WB;
                    endcase
                end
            end
            // data bus shared with the load writeback
            M_DATA_REQ:
            begin
                if (!wb_busy)
                    next_state = d_odv ? M_IDLE : M_DATA_HOLD;
            end
            M_DATA_HOLD:    if (d_odv) next_state = M_IDLE;
            M_IO_WAIT:      if (hs_in) next_state = M_IO_HANDSHAKE;
            M_IO_HANDSHAKE:
            begin
                if (!hs_in)
                    next_state = (cur_job.wb_kind == WB_NONE) ? M_IDLE : M_WB;
            end
            M_WB:           if (!wb_busy) next_state = M_IDLE;
            default:        next_state = M_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////

    always_comb
    begin
        mem_ctrl = '0;
        pop = 1'b0;
        wb_start = 1'b0;
        hs_out = 1'b0;
        case (state)
            M_IDLE:      pop = !empty;
            M_DATA_REQ:
            begin
                // a load hands its writeback over with the first d_req
                mem_ctrl.d_req = !wb_busy;
                mem_ctrl.d_write = !wb_busy && is_store;
                wb_start = !wb_busy && (cur_job.mem_kind == MEM_LOAD);
            end
            M_DATA_HOLD:
            begin
                mem_ctrl.d_req = 1'b1;
                mem_ctrl.d_write = is_store;
            end
            M_IO_WAIT:
            begin
                mem_ctrl.io_sel = 1'b1;
                mem_ctrl.io_dir = is_out;
            end
            M_IO_HANDSHAKE:
            begin
                mem_ctrl.io_sel = 1'b1;
                mem_ctrl.io_dir = is_out;
                hs_out = 1'b1;
            end
            M_WB:        wb_start = !wb_busy;
            default:     pop = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== memstage/writeback_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module writeback_sequencer
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     wb_start,
    input  wire wb_kind_t wb_kind,
    input  wire logic     d_odv,
    output logic          wb_busy,
    output wb_ctrl_t      wb_ctrl
);

    typedef enum logic [2:0]
    {
        W_IDLE,
        W_ALU,
        W_PC,
        W_MEM_WAIT,
        W_MEM
    } wb_state_t;

    wb_state_t state;
    wb_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= W_IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            W_IDLE:
            begin
                if (wb_start)
                begin
                    case (wb_kind)
                        WB_ALU:  next_state = W_ALU;
                        WB_PC:   next_state = W_PC;
                        // load data may already be on the bus
                        WB_MEM:  next_state = d_odv ? W_MEM : W_MEM_WAIT;
                        default: next_state = W_IDLE;
                    endcase
                end
            end
            W_MEM_WAIT: if (d_odv) next_state = W_MEM;
            default:    next_state = W_IDLE;
        endcase
    end

    assign wb_busy = (state != W_IDLE);

    always_comb
    begin
        wb_ctrl = '0;
        case (state)
            W_ALU:   wb_ctrl.reg_write = 1'b1;
            W_PC:    wb_ctrl.pc_write = 1'b1;
            W_MEM:
            begin
                wb_ctrl.reg_write = 1'b1;
                wb_ctrl.reg_src_mem = 1'b1;
            end
            default: wb_ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verif
common/isa_pkg.sv
common/ctrl_pkg.sv
hdl/job_queue.sv
fetch/fetch_sequencer.sv
memstage/writeback_sequencer.sv
memstage/mem_sequencer.sv
hdl/pipe_ctrl_top.sv
verif/tb_pipe_ctrl.sv

// ==== verif/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH
`default_nettype none

//////////////////////////////////////////////////
// typed compares
//////////////////////////////////////////////////

task automatic check_wb(input string what, input wb_ctrl_t got, input wb_ctrl_t exp);
    if (got !== exp)
    begin
        $display("mismatch %s: got %h expected %h", what, got, exp);
        errors++;
    end
endtask

task automatic check_exec(input string what, input exec_ctrl_t got, input exec_ctrl_t exp);
    if (got !== exp)
    begin
        $display("mismatch %s: got %h expected %h", what, got, exp);
        errors++;
    end
endtask

task automatic check_mem(input string what, input mem_ctrl_t got, input mem_ctrl_t exp);
    if (got !== exp)
    begin
        $display("mismatch %s: got %h expected %h", what, got, exp);
        errors++;
    end
endtask

task automatic check_fetch(input string what, input fetch_ctrl_t got, input fetch_ctrl_t exp);
    if (got !== exp)
    begin
        $display("mismatch %s: got %h expected %h", what, got, exp);
        errors++;
    end
endtask

task automatic check_level(input string what, input int got, input int exp);
    if (got !== exp)
    begin
        $display("mismatch %s: got %h expected %h", what, got, exp);
        errors++;
    end
endtask

//////////////////////////////////////////////////
// program and expectations
//////////////////////////////////////////////////

task automatic clear_logs();
    exec_log.delete();
    wb_log.delete();
    mem_log.delete();
    ev_log.delete();
    exp_exec.delete();
    exp_wb.delete();
    exp_mem.delete();
    exp_ev.delete();
endtask

// queues one instruction and what it should cause
task automatic add_instr(input opcode_t op);
    prog.push_back(op);
    exp_ev.push_back(EV_IR);
    if (op < 6'o40)
    begin
        if (op[0])
            exp_ev.push_back(EV_OPERAND);
        exp_exec.push_back({1'b1, op[4:0], 1'b0});
        exp_wb.push_back(3'b100);
    end
    else if (op == OP_LOAD)
    begin
        exp_mem.push_back(4'b1000);
        exp_wb.push_back(3'b110);
    end
    else if (op == OP_STORE)
        exp_mem.push_back(4'b1100);
    else if (op == OP_JUMP)
        exp_wb.push_back(3'b001);
    else if (op != OP_IN && op != OP_OUT)
        exp_exec.push_back(7'b0000001);
endtask

task automatic wait_logs(input string what);
    int n;
    n = 0;
    while ((wb_log.size() < exp_wb.size() || exec_log.size() < exp_exec.size() ||
            mem_log.size() < exp_mem.size() || ev_log.size() < exp_ev.size()) && n < TIMEOUT)
    begin
        @(negedge clk);
        n++;
    end
    if (n >= TIMEOUT)
    begin
        $display("timeout in %s waiting for the expected activity", what);
        errors++;
    end
    // extra strobes would show up here
    repeat (20) @(negedge clk);
endtask

task automatic compare_all();
    if (exec_log.size() != exp_exec.size())
    begin
        $display("got %0d execute strobes, expected %0d", exec_log.size(), exp_exec.size());
        errors++;
    end
    else
        foreach (exec_log[i]) check_exec("exec_ctrl", exec_log[i], exp_exec[i]);
    if (wb_log.size() != exp_wb.size())
    begin
        $display("got %0d writebacks, expected %0d", wb_log.size(), exp_wb.size());
        errors++;
    end
    else
        foreach (wb_log[i]) check_wb("wb_ctrl", wb_log[i], exp_wb[i]);
    if (mem_log.size() != exp_mem.size())
    begin
        $display("got %0d data accesses, expected %0d", mem_log.size(), exp_mem.size());
        errors++;
    end
    else
        foreach (mem_log[i]) check_mem("mem_ctrl", mem_log[i], exp_mem[i]);
    if (ev_log.size() != exp_ev.size())
    begin
        $display("got %0d fetch events, expected %0d", ev_log.size(), exp_ev.size());
        errors++;
    end
    else
        foreach (ev_log[i]) check_level("fetch_event", ev_log[i], exp_ev[i]);
endtask

task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors)
        $display("test %s passed", name);
    else
        $display("test %s failed with %0d errors", name, errors - start_errors);
endtask

task automatic wait_ev_count(input int count, input string what);
    int n;
    n = 0;
    while (ev_log.size() < count && n < TIMEOUT)
    begin
        @(negedge clk);
        n++;
    end
    if (n >= TIMEOUT)
    begin
        $display("timeout waiting for %s", what);
        errors++;
    end
endtask

task automatic wait_hs_out(input logic level);
    int n;
    n = 0;
    while (hs_out !== level && n < TIMEOUT)
    begin
        @(negedge clk);
        n++;
    end
    if (n >= TIMEOUT)
    begin
        $display("timeout waiting for hs_out to become %0d", level);
        errors++;
    end
endtask

// four-phase exchange on the io port
task automatic io_handshake(input mem_ctrl_t exp);
    int n;
    n = 0;
    while (!mem_ctrl.io_sel && n < TIMEOUT)
    begin
        @(negedge clk);
        n++;
    end
    if (n >= TIMEOUT)
    begin
        $display("timeout waiting for io_sel");
        errors++;
    end
    check_mem("mem_ctrl", mem_ctrl, exp);
    repeat (3) @(negedge clk);
    check_level("hs_out", hs_out, 0);
    @(posedge clk);
    hs_in <= 1'b1;
    wait_hs_out(1'b1);
    repeat (2) @(negedge clk);
    @(posedge clk);
    hs_in <= 1'b0;
    wait_hs_out(1'b0);
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic test_reset();
    int start;
    start = errors;
    @(negedge clk);
    check_fetch("fetch_ctrl", fetch_ctrl, '0);
    check_exec("exec_ctrl", exec_ctrl, '0);
    check_mem("mem_ctrl", mem_ctrl, '0);
    check_wb("wb_ctrl", wb_ctrl, '0);
    check_level("hs_out", hs_out, 0);
    finish_test("reset", start);
endtask

task automatic test_alu();
    int start;
    start = errors;
    clear_logs();
    add_instr(6'o02);
    add_instr(6'o04);
    add_instr(6'o16);
    add_instr(6'o36);
    add_instr(6'o00);
    wait_logs("alu");
    compare_all();
    finish_test("alu", start);
endtask

task automatic test_immediate();
    int start;
    start = errors;
    clear_logs();
    add_instr(6'o03);
    add_instr(6'o47);
    add_instr(6'o11);
    add_instr(6'o77);
    add_instr(6'o37);
    wait_logs("immediate");
    compare_all();
    finish_test("immediate", start);
endtask

task automatic test_data();
    int start;
    start = errors;
    clear_logs();
    add_instr(OP_LOAD);
    add_instr(OP_STORE);
    add_instr(OP_JUMP);
    add_instr(6'o06);
    add_instr(OP_LOAD);
    add_instr(6'o13);
    wait_logs("data");
    compare_all();
    finish_test("data", start);
endtask

task automatic test_io();
    int start;
    start = errors;
    clear_logs();
    add_instr(OP_IN);
    add_instr(OP_OUT);
    io_handshake(4'b0010);
    io_handshake(4'b0011);
    wait_logs("io");
    compare_all();
    finish_test("io", start);
endtask

task automatic test_interrupt();
    int start;
    start = errors;
    clear_logs();
    add_instr(6'o10);
    exp_ev.push_back(EV_RELOAD);
    exp_ev.push_back(EV_SAVE);
    exp_ev.push_back(EV_VECTOR);
    add_instr(OP_JUMP);
    wait_ev_count(1, "first ir_load");
    @(posedge clk);
    pc_w <= 1'b1;
    i_pending <= 1'b1;
    wait_ev_count(2, "pc_reload");
    @(posedge clk);
    pc_w <= 1'b0;
    wait_ev_count(3, "int_save");
    @(posedge clk);
    i_pending <= 1'b0;
    wait_logs("interrupt");
    compare_all();
    finish_test("interrupt", start);
endtask

`default_nettype wire
`endif

// ==== verif/tb_pipe_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pipe_ctrl
    import isa_pkg::*, ctrl_pkg::*;
();

    localparam int TIMEOUT = 500;

    // fetch-side events in the order they are seen
    localparam int EV_IR      = 1;
    localparam int EV_OPERAND = 2;
    localparam int EV_RELOAD  = 3;
    localparam int EV_SAVE    = 4;
    localparam int EV_VECTOR  = 5;

    logic    clk = 1'b0;
    logic    reset = 1'b1;
    opcode_t opcode = '0;
    logic    i_odv = 1'b0;
    logic    d_odv = 1'b0;
    logic    hs_in = 1'b0;
    logic    i_pending = 1'b0;
    logic    pc_w = 1'b0;

    fetch_ctrl_t fetch_ctrl;
    exec_ctrl_t  exec_ctrl;
    mem_ctrl_t   mem_ctrl;
    wb_ctrl_t    wb_ctrl;
    logic        hs_out;

    int errors = 0;
    int tests_run = 0;
    int seed = 20446;

    // program words waiting to be fetched
    opcode_t prog[$];
    logic    imm_next = 1'b0;
    int      i_wait = 0;
    int      d_wait = 0;

    // observed and expected activity
    exec_ctrl_t exec_log[$];
    wb_ctrl_t   wb_log[$];
    mem_ctrl_t  mem_log[$];
    int         ev_log[$];
    exec_ctrl_t exp_exec[$];
    wb_ctrl_t   exp_wb[$];
    mem_ctrl_t  exp_mem[$];
    int         exp_ev[$];

    logic last_d_req = 1'b0;
    logic last_hs_out = 1'b0;

    pipe_ctrl_top #(.FIFO_DEPTH(4)) u_dut
    (
        .clk        (clk),
        .reset      (reset),
        .opcode     (opcode),
        .i_odv      (i_odv),
        .d_odv      (d_odv),
        .hs_in      (hs_in),
        .i_pending  (i_pending),
        .pc_w       (pc_w),
        .fetch_ctrl (fetch_ctrl),
        .exec_ctrl  (exec_ctrl),
        .mem_ctrl   (mem_ctrl),
        .wb_ctrl    (wb_ctrl),
        .hs_out     (hs_out)
    );

    initial
    begin
        forever #2 clk = ~clk;
    end

    function automatic int next_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    //////////////////////////////////////////////////
    // bus responders
    //////////////////////////////////////////////////

    // instruction bus
    // the word after an immediate opcode is its operand
    always @(posedge clk)
    begin
        if (reset || i_odv)
        begin
            i_odv <= 1'b0;
        end
        else if (fetch_ctrl.i_req)
        begin
            if (i_wait > 0)
            begin
                i_wait <= i_wait - 1;
            end
            else if (imm_next)
            begin
                i_odv <= 1'b1;
                imm_next <= 1'b0;
                i_wait <= next_delay();
            end
            else if (prog.size() > 0)
            begin
                opcode <= prog[0];
                imm_next <= (prog[0] < 6'o40) && prog[0][0];
                prog.pop_front();
                i_odv <= 1'b1;
                i_wait <= next_delay();
            end
        end
    end

    // data bus
    always @(posedge clk)
    begin
        if (reset || d_odv)
            d_odv <= 1'b0;
        else if (mem_ctrl.d_req && d_wait > 0)
            d_wait <= d_wait - 1;
        else if (mem_ctrl.d_req)
            d_odv <= 1'b1;
        else
            d_wait <= next_delay();
    end

    //////////////////////////////////////////////////
    // monitor
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (fetch_ctrl.pc_reload)
                ev_log.push_back(EV_RELOAD);
            if (fetch_ctrl.int_save)
                ev_log.push_back(EV_SAVE);
            if (fetch_ctrl.int_vector)
                ev_log.push_back(EV_VECTOR);
            if (fetch_ctrl.ir_load)
                ev_log.push_back(EV_IR);
            if (fetch_ctrl.operand_load)
                ev_log.push_back(EV_OPERAND);
            // pc only steps over words taken from the bus
            if (fetch_ctrl.operand_load && !fetch_ctrl.pc_inc)
            begin
                $display("operand_load came without pc_inc");
                errors++;
            end
            if (fetch_ctrl.pc_inc && !i_odv)
            begin
                $display("pc_inc came without a word on the instruction bus");
                errors++;
            end
            if (exec_ctrl.alu_en || exec_ctrl.trap)
                exec_log.push_back(exec_ctrl);
            if (wb_ctrl != '0)
                wb_log.push_back(wb_ctrl);
            // one entry per data access
            if (mem_ctrl.d_req && !last_d_req)
                mem_log.push_back(mem_ctrl);
            if (hs_out && !last_hs_out && !hs_in)
            begin
                $display("hs_out rose while hs_in was low");
                errors++;
            end
            if (!hs_out && last_hs_out && hs_in)
            begin
                $display("hs_out fell while hs_in was still high");
                errors++;
            end
        end
        last_d_req = mem_ctrl.d_req;
        last_hs_out = hs_out;
    end

    `include "tb_tasks.svh"

    initial
    begin
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_alu();
        test_immediate();
        test_data();
        test_io();
        test_interrupt();
        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
